/* Makefile */
TOP = weight_cache_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -o $(TOP)

run: build
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

/* design/wcache_ctrl.sv */
// The mode is sampled only on the configuration transfer and any cfg_valid in WORK drops to IDLE
`default_nettype none

module wcache_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic cfg_valid,
    input  logic cfg_cache_en,
    output logic cfg_ready,
    output logic active,
    output logic cache_en,
    output logic clear
);

    wcache_pkg::cache_state_e state;
    wcache_pkg::cache_state_e next_state;

    // ==============================
    // State machine
    // ==============================
    always_comb begin
        next_state = state;
        case (state)
            wcache_pkg::IDLE: begin
                if (cfg_valid) begin
                    next_state = wcache_pkg::CFG;
                end
            end
            wcache_pkg::CFG: next_state = wcache_pkg::WORK;    // One setup cycle
            wcache_pkg::WORK: begin
                if (cfg_valid) begin
                    next_state = wcache_pkg::IDLE;
                end
            end
            default: next_state = wcache_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= wcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Mode register, dropped back to bypass while idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_en <= 1'b0;
        end else if (cfg_valid && cfg_ready) begin
            cache_en <= cfg_cache_en;
        end else if (state == wcache_pkg::IDLE) begin
            cache_en <= 1'b0;
        end
    end

    assign cfg_ready = (state == wcache_pkg::IDLE);
    assign clear     = (state == wcache_pkg::IDLE);    // Hit store wiped
    assign active    = (state == wcache_pkg::WORK);

    // Working state and its mode hold until the configuration side asks
    a_work_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (active && !cfg_valid) |=> active && $stable(cache_en));

endmodule

`default_nettype wire

/* design/wcache_hit_store.sv */
// Weights must not change in memory during WORK since stored copies are never refreshed
`default_nettype none

module wcache_hit_store (
    input  logic                                                 clk,
    input  logic                                                 rst_n,
    input  logic                                                 active,
    input  logic                                                 cache_en,
    input  logic                                                 clear,
    input  wcache_pkg::weight_addr_t [wcache_pkg::NUM_ROWS-1:0] lookup_addr,
    input  logic                                                 fill_valid,
    input  wcache_pkg::weight_addr_t                             fill_addr,
    input  wcache_pkg::weight_t                                  fill_data,
    output logic [wcache_pkg::NUM_ROWS-1:0]                      hit,
    output wcache_pkg::weight_t [wcache_pkg::NUM_ROWS-1:0]      hit_data
);

    // ==============================
    // Storage
    // ==============================
    wcache_pkg::weight_addr_t           tag_mem  [wcache_pkg::NUM_ENTRIES];
    wcache_pkg::weight_t                data_mem [wcache_pkg::NUM_ENTRIES];
    logic [wcache_pkg::NUM_ENTRIES-1:0] tag_valid;
    wcache_pkg::entry_idx_t             fill_ptr;      // Round-robin victim slot

    wcache_pkg::weight_addr_t last_addr;               // Last weight read from memory
    wcache_pkg::weight_t      last_data;
    logic                     last_valid;

    logic fill_match;
    logic store_wr;
    logic tag_dup;

    always_comb begin
        fill_match = 1'b0;
        for (int e = 0; e < wcache_pkg::NUM_ENTRIES; e++) begin
            if (tag_valid[e] && tag_mem[e] == fill_addr) begin
                fill_match = 1'b1;
            end
        end
    end

    // New slot only for an address not held yet
    assign store_wr = fill_valid && cache_en && !fill_match && !clear;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_valid <= '0;
            fill_ptr  <= '0;
        end else if (clear) begin
            tag_valid <= '0;
            fill_ptr  <= '0;
        end else if (store_wr) begin
            tag_valid[fill_ptr] <= 1'b1;
            fill_ptr            <= fill_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store_wr) begin
            tag_mem[fill_ptr]  <= fill_addr;
            data_mem[fill_ptr] <= fill_data;
        end
    end

    // Last-access register follows every fill
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_valid <= 1'b0;
        end else if (clear) begin
            last_valid <= 1'b0;
        end else if (fill_valid) begin
            last_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_valid) begin
            last_addr <= fill_addr;
            last_data <= fill_data;
        end
    end

    // ==============================
    // Per-row lookup
    // ==============================
    always_comb begin
        for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
            hit[r]      = last_valid && last_addr == lookup_addr[r];
            hit_data[r] = last_data;
            for (int e = 0; e < wcache_pkg::NUM_ENTRIES; e++) begin
                if (tag_valid[e] && tag_mem[e] == lookup_addr[r]) begin
                    hit[r]      = 1'b1;
                    hit_data[r] = data_mem[e];
                end
            end
            hit[r] = hit[r] && active && cache_en;    // Bypass never hits
        end
    end

    always_comb begin
        tag_dup = 1'b0;
        for (int i = 0; i < wcache_pkg::NUM_ENTRIES; i++) begin
            for (int j = i + 1; j < wcache_pkg::NUM_ENTRIES; j++) begin
                if (tag_valid[i] && tag_valid[j] && tag_mem[i] == tag_mem[j]) begin
                    tag_dup = 1'b1;
                end
            end
        end
    end

    // Two rows may miss on one address, so the second fill must find the first
    a_tags_unique: assert property (@(posedge clk) disable iff (!rst_n) !tag_dup);

endmodule

`default_nettype wire

/* design/wcache_miss_arb.sv */
// Only one memory read is open and mem_rsp_valid here must be the completed data transfer
`default_nettype none

module wcache_miss_arb (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [wcache_pkg::NUM_ROWS-1:0]                  miss_valid,
    input  wcache_pkg::row_req_t [wcache_pkg::NUM_ROWS-1:0] miss_req,
    output logic                                             mem_req_valid,
    output wcache_pkg::row_req_t                             mem_req,
    input  logic                                             mem_req_ready,
    input  logic                                             mem_rsp_valid,
    output wcache_pkg::row_idx_t                             grant_row,
    output wcache_pkg::row_idx_t                             rsp_row,
    output logic                                             fill_valid,
    output wcache_pkg::weight_addr_t                         fill_addr
);

    logic                     busy;            // Read issued, data not back yet
    wcache_pkg::row_idx_t     last_grant;
    wcache_pkg::weight_addr_t pend_addr;       // Address of the open read
    logic                     req_fire;

    // ==============================
    // Round-robin grant
    // ==============================
    always_comb begin
        wcache_pkg::row_idx_t cand;
        logic                 found;
        grant_row = last_grant;
        found     = 1'b0;
        // Search starts one past the last winner
        for (int k = 1; k <= wcache_pkg::NUM_ROWS; k++) begin
            cand = wcache_pkg::row_idx_t'(int'(last_grant) + k);
            if (!found && miss_valid[cand]) begin
                grant_row = cand;
                found     = 1'b1;
            end
        end
    end

    assign mem_req_valid = !busy && |miss_valid;
    assign mem_req       = miss_req[grant_row];
    assign req_fire      = mem_req_valid && mem_req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rsp_row    <= '0;
            last_grant <= wcache_pkg::row_idx_t'(wcache_pkg::NUM_ROWS - 1);    // Row 0 first
        end else if (req_fire) begin
            busy       <= 1'b1;
            rsp_row    <= grant_row;
            last_grant <= grant_row;
        end else if (mem_rsp_valid) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_fire) begin
            pend_addr <= mem_req.addr;
        end
    end

    // Fill the hit store with the returning weight
    assign fill_valid = mem_rsp_valid && busy;
    assign fill_addr  = pend_addr;

    // Memory must never answer a read that was not issued
    a_rsp_needs_read: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> busy);

endmodule

`default_nettype wire

/* design/wcache_pkg.sv */
// Sizes are fixed for four rows and eight entries and the row count must stay a power of two
`default_nettype none

package wcache_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int NUM_ROWS    = 4;
    localparam int NUM_ENTRIES = 8;    // Fully associative slots
    localparam int WADDR_W     = 13;
    localparam int WEIGHT_W    = 8;

    // ==============================
    // Vector types
    // ==============================
    typedef logic [WADDR_W-1:0]             weight_addr_t;
    typedef logic [WEIGHT_W-1:0]            weight_t;
    typedef logic [$clog2(NUM_ROWS)-1:0]    row_idx_t;
    typedef logic [$clog2(NUM_ENTRIES)-1:0] entry_idx_t;

    // Control FSM
    typedef enum logic [1:0] {
        IDLE = 2'd0,    // Cache empty, waiting for configuration
        CFG  = 2'd1,
        WORK = 2'd2
    } cache_state_e;

    // Row request, also what goes out on the memory read port
    typedef struct packed {
        weight_addr_t addr;
        logic         last;
    } row_req_t;

    // Weight back to a row, also the memory read data
    typedef struct packed {
        weight_t data;
        logic    last;      // Echo of the request's last flag
    } row_rsp_t;

endpackage

`default_nettype wire

/* design/wcache_row_port.sv */
// One request in flight per row and grant_row marks this row's memory address transfer
`default_nettype none

module wcache_row_port (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 active,
    input  logic                 req_valid,
    input  wcache_pkg::row_req_t req,
    output logic                 req_ready,
    input  logic                 hit,
    input  wcache_pkg::weight_t  hit_data,
    output logic                 miss_valid,
    input  logic                 grant_row,        // This row's miss transfers now
    input  logic                 rsp_row,          // This row owns the open read
    input  logic                 mem_rsp_valid,
    input  wcache_pkg::row_rsp_t mem_rsp,
    output logic                 rsp_valid,
    output wcache_pkg::row_rsp_t rsp,
    output logic                 mem_rsp_ready,
    input  logic                 rsp_ready
);

    logic                 hit_valid;               // One-entry hit response
    wcache_pkg::row_rsp_t hit_rsp;
    logic                 pending;                 // Miss sent, data not delivered
    logic                 hit_take;
    logic                 miss_take;
    logic                 mem_owned;

    // ==============================
    // Request acceptance
    // ==============================
    // A held hit response may leave on the same edge a new hit comes in
    assign hit_take   = active && req_valid && hit && !pending && (!hit_valid || rsp_ready);
    assign miss_valid = active && req_valid && !hit && !pending && !hit_valid;
    assign miss_take  = miss_valid && grant_row;
    assign req_ready  = hit_take || miss_take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_valid <= 1'b0;
        end else if (hit_take) begin
            hit_valid <= 1'b1;
        end else if (rsp_ready) begin
            hit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_take) begin
            hit_rsp.data <= hit_data;
            hit_rsp.last <= req.last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (miss_take) begin
            pending <= 1'b1;
        end else if (mem_owned && mem_rsp_valid && rsp_ready) begin
            pending <= 1'b0;
        end
    end

    // ==============================
    // Response mux
    // ==============================
    assign mem_owned     = pending && rsp_row;
    assign rsp_valid     = mem_owned ? mem_rsp_valid : hit_valid;
    assign rsp           = mem_owned ? mem_rsp : hit_rsp;
    assign mem_rsp_ready = mem_owned && rsp_ready;    // Memory waits on this row

    // Memory data for this row only shows up while no hit response is held
    a_one_source: assert property (@(posedge clk) disable iff (!rst_n)
        hit_valid |-> !(rsp_row && mem_rsp_valid));

endmodule

`default_nettype wire

/* design/weight_cache_top.sv */
// Memory must return read data in request order and hold no read open across reset
`default_nettype none

module weight_cache_top (
    input  logic                                             clk,
    input  logic                                             rst_n,
    // Configuration
    input  logic                                             cfg_valid,
    input  logic                                             cfg_cache_en,
    output logic                                             cfg_ready,
    // Rows
    input  logic [wcache_pkg::NUM_ROWS-1:0]                  req_valid,
    input  wcache_pkg::row_req_t [wcache_pkg::NUM_ROWS-1:0] req,
    output logic [wcache_pkg::NUM_ROWS-1:0]                  req_ready,
    output logic [wcache_pkg::NUM_ROWS-1:0]                  rsp_valid,
    output wcache_pkg::row_rsp_t [wcache_pkg::NUM_ROWS-1:0] rsp,
    input  logic [wcache_pkg::NUM_ROWS-1:0]                  rsp_ready,
    // Memory read port
    output logic                                             mem_req_valid,
    output wcache_pkg::row_req_t                             mem_req,
    input  logic                                             mem_req_ready,
    input  logic                                             mem_rsp_valid,
    input  wcache_pkg::row_rsp_t                             mem_rsp,
    output logic                                             mem_rsp_ready
);

    logic                                               active;
    logic                                               cache_en;
    logic                                               clear;
    logic [wcache_pkg::NUM_ROWS-1:0]                    hit;
    wcache_pkg::weight_t [wcache_pkg::NUM_ROWS-1:0]    hit_data;
    wcache_pkg::weight_addr_t [wcache_pkg::NUM_ROWS-1:0] lookup_addr;
    logic [wcache_pkg::NUM_ROWS-1:0]                    miss_valid;
    wcache_pkg::row_idx_t                               grant_row;
    wcache_pkg::row_idx_t                               rsp_row;
    logic                                               fill_valid;
    wcache_pkg::weight_addr_t                           fill_addr;
    logic [wcache_pkg::NUM_ROWS-1:0]                    row_mem_rsp_ready;
    logic                                               mem_req_fire;
    logic                                               mem_rsp_fire;

    assign mem_req_fire  = mem_req_valid && mem_req_ready;
    assign mem_rsp_ready = |row_mem_rsp_ready;    // Only the owning row can be ready
    assign mem_rsp_fire  = mem_rsp_valid && mem_rsp_ready;

    wcache_ctrl u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_valid    (cfg_valid),
        .cfg_cache_en (cfg_cache_en),
        .cfg_ready    (cfg_ready),
        .active       (active),
        .cache_en     (cache_en),
        .clear        (clear)
    );

    wcache_hit_store u_hit_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .cache_en    (cache_en),
        .clear       (clear),
        .lookup_addr (lookup_addr),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_data   (mem_rsp.data),
        .hit         (hit),
        .hit_data    (hit_data)
    );

    // Arbiter sees completed data transfers only
    wcache_miss_arb u_miss_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .miss_valid    (miss_valid),
        .miss_req      (req),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_fire),
        .grant_row     (grant_row),
        .rsp_row       (rsp_row),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr)
    );

    // ==============================
    // Row ports
    // ==============================
    for (genvar g = 0; g < wcache_pkg::NUM_ROWS; g++) begin : g_row
        assign lookup_addr[g] = req[g].addr;

        wcache_row_port u_row_port (
            .clk           (clk),
            .rst_n         (rst_n),
            .active        (active),
            .req_valid     (req_valid[g]),
            .req           (req[g]),
            .req_ready     (req_ready[g]),
            .hit           (hit[g]),
            .hit_data      (hit_data[g]),
            .miss_valid    (miss_valid[g]),
            .grant_row     (mem_req_fire && grant_row == wcache_pkg::row_idx_t'(g)),
            .rsp_row       (rsp_row == wcache_pkg::row_idx_t'(g)),
            .mem_rsp_valid (mem_rsp_valid),
            .mem_rsp       (mem_rsp),
            .rsp_valid     (rsp_valid[g]),
            .rsp           (rsp[g]),
            .mem_rsp_ready (row_mem_rsp_ready[g]),
            .rsp_ready     (rsp_ready[g])
        );
    end

endmodule

`default_nettype wire

/* project.f */
design/wcache_pkg.sv
design/wcache_ctrl.sv
design/wcache_miss_arb.sv
design/wcache_hit_store.sv
design/wcache_row_port.sv
design/weight_cache_top.sv
verification/weight_cache_tb.sv

/* verification/weight_cache_cases.txt */
# Columns are kind mode row addr(hex) last weight(hex) reads(decimal)
# Kinds are C configure  I back to idle  R one request  P queue for batch  G run batch
C 0 0 0000 0 00 0
R 0 0 0123 1 79 1
R 0 0 0123 0 79 1
R 0 2 1abc 1 e6 1
I 0 0 0000 0 00 0
C 1 0 0000 0 00 0
R 0 1 0040 0 1a 1
R 0 1 0040 1 1a 0
R 0 3 0040 0 1a 0
R 0 0 0041 1 1b 1
R 0 0 0040 0 1a 0
I 0 0 0000 0 00 0
C 1 0 0000 0 00 0
R 0 0 0040 0 1a 1
I 0 0 0000 0 00 0
C 1 0 0000 0 00 0
R 0 0 0100 0 5a 1
R 0 1 0101 0 5b 1
R 0 2 0102 0 58 1
R 0 3 0103 0 59 1
R 0 0 0104 0 5e 1
R 0 1 0105 0 5f 1
R 0 2 0106 0 5c 1
R 0 3 0107 0 5d 1
R 0 0 0108 1 52 1
R 0 1 0100 0 5a 1
R 0 2 0108 1 52 0
I 0 0 0000 0 00 0
C 1 0 0000 0 00 0
P 0 0 0200 0 5a 0
P 0 0 0201 0 5b 0
P 0 0 0202 1 58 0
P 0 1 0310 0 4a 0
P 0 1 0311 1 4b 0
P 0 1 0312 0 48 0
P 0 2 0420 1 7a 0
P 0 2 0421 0 7b 0
P 0 2 0422 1 78 0
P 0 3 1530 0 6a 0
P 0 3 1531 0 6b 0
P 0 3 1532 1 68 0
G 0 0 0000 0 00 12
I 0 0 0000 0 00 0
C 0 0 0000 0 00 0
P 0 0 0050 1 0a 0
P 0 1 0050 0 0a 0
P 0 2 0050 1 0a 0
P 0 3 0050 0 0a 0
G 0 0 0000 0 00 4
I 0 0 0000 0 00 0

/* verification/weight_cache_tb.sv */
// Run from the project root since the case file path is relative and memory answers one read at a time
`default_nettype none

module weight_cache_tb;

    localparam int WAIT_LIMIT = 2000;    // Cycles before any wait gives up
    localparam int DEPTH      = 16;      // Requests per row in one batch

    logic                                             clk = 1'b0;
    logic                                             rst_n;
    logic                                             cfg_valid;
    logic                                             cfg_cache_en;
    logic                                             cfg_ready;
    logic [wcache_pkg::NUM_ROWS-1:0]                  req_valid;
    wcache_pkg::row_req_t [wcache_pkg::NUM_ROWS-1:0] req;
    logic [wcache_pkg::NUM_ROWS-1:0]                  req_ready;
    logic [wcache_pkg::NUM_ROWS-1:0]                  rsp_valid;
    wcache_pkg::row_rsp_t [wcache_pkg::NUM_ROWS-1:0] rsp;
    logic [wcache_pkg::NUM_ROWS-1:0]                  rsp_ready;
    logic                                             mem_req_valid;
    wcache_pkg::row_req_t                             mem_req;
    logic                                             mem_req_ready;
    logic                                             mem_rsp_valid;
    wcache_pkg::row_rsp_t                             mem_rsp;
    logic                                             mem_rsp_ready;

    // Memory side bookkeeping
    logic                 req_fired = 1'b0;
    logic                 rsp_fired = 1'b0;
    wcache_pkg::row_req_t held_req  = '0;    // Address of the read being served
    int                   mem_reads = 0;

    // Expected and observed traffic of one batch
    wcache_pkg::row_req_t exp_req    [wcache_pkg::NUM_ROWS][DEPTH];
    wcache_pkg::weight_t  exp_weight [wcache_pkg::NUM_ROWS][DEPTH];
    int                   exp_cnt    [wcache_pkg::NUM_ROWS];
    wcache_pkg::row_rsp_t got_rsp    [wcache_pkg::NUM_ROWS][DEPTH];
    int                   got_cnt    [wcache_pkg::NUM_ROWS];

    int   errors    = 0;
    int   checks    = 0;
    int   cases_run = 0;
    logic aborted   = 1'b0;    // Run cut short by a timeout or a bad case line

    weight_cache_top dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_valid     (cfg_valid),
        .cfg_cache_en  (cfg_cache_en),
        .cfg_ready     (cfg_ready),
        .req_valid     (req_valid),
        .req           (req),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .rsp_ready     (rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    always #10 clk = ~clk;

    // ==============================
    // Memory model
    // ==============================
    // Handshakes seen before the DUT updates on the same edge
    always @(posedge clk) begin
        req_fired <= mem_req_valid && mem_req_ready;
        rsp_fired <= mem_rsp_valid && mem_rsp_ready;
        if (mem_req_valid && mem_req_ready) begin
            held_req  <= mem_req;
            mem_reads <= mem_reads + 1;
        end
    end

    initial begin : memory_model
        int   delay;
        logic waiting;
        delay         = 0;
        waiting       = 1'b0;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        forever begin
            @(negedge clk);
            if (rsp_fired) begin
                mem_rsp_valid = 1'b0;
                mem_req_ready = 1'b1;
            end
            if (req_fired) begin
                mem_req_ready = 1'b0;
                delay         = $urandom_range(3, 0);    // 0 to 3 idle cycles
                waiting       = 1'b1;
            end
            if (waiting) begin
                if (delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp.data  = held_req.addr[7:0] ^ 8'h5a;
                    mem_rsp.last  = held_req.last;
                    waiting       = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    // Random row back-pressure
    initial begin : backpressure
        rsp_ready = '0;
        forever begin
            @(negedge clk);
            for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
                rsp_ready[r] = ($urandom_range(3, 0) != 0);    // Stall about one cycle in four
            end
        end
    end

    // ==============================
    // Checks and flow control
    // ==============================
    task automatic check_value(input logic ok, input string what);
        checks++;
        assert (ok) else begin
            $display("FAILED at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic drive_config(input logic mode);
        int   cycles;
        logic done;
        check_value(cfg_ready, "cfg_ready low before configuration");
        @(negedge clk);
        cfg_valid    = 1'b1;
        cfg_cache_en = mode;
        cycles       = 0;
        done         = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = cfg_ready;
            cycles++;
            if (!done && cycles >= WAIT_LIMIT) begin
                abort_run("timeout: configuration transfer never happened");
                return;
            end
        end
        @(negedge clk);
        cfg_valid = 1'b0;
        check_value(!cfg_ready, "cfg_ready still high after configuration transfer");
        @(negedge clk);    // CFG to WORK
    endtask

    task automatic return_to_idle();
        @(negedge clk);
        cfg_valid = 1'b1;
        @(negedge clk);
        cfg_valid = 1'b0;
        check_value(cfg_ready, "cfg_ready not back after leaving WORK");
    endtask

    task automatic queue_request(input int row, input int addr, input int last, input int weight);
        if (exp_cnt[row] >= DEPTH) begin
            abort_run("too many requests queued for one row");
            return;
        end
        exp_req[row][exp_cnt[row]].addr = wcache_pkg::weight_addr_t'(addr);
        exp_req[row][exp_cnt[row]].last = last[0];
        exp_weight[row][exp_cnt[row]]   = wcache_pkg::weight_t'(weight);
        exp_cnt[row]++;
    endtask

    // All rows drive their queued requests at once
    task automatic run_batch(input int exp_reads);
        int   sent [wcache_pkg::NUM_ROWS];
        int   reads_before;
        int   cycles;
        logic done;
        reads_before = mem_reads;
        cycles       = 0;
        done         = 1'b0;
        for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
            sent[r]    = 0;
            got_cnt[r] = 0;
        end
        while (!done) begin
            @(negedge clk);
            for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
                req_valid[r] = (sent[r] < exp_cnt[r]);
                if (sent[r] < exp_cnt[r]) begin
                    req[r] = exp_req[r][sent[r]];
                end
            end
            @(posedge clk);
            done = 1'b1;
            for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
                if (req_valid[r] && req_ready[r]) begin
                    sent[r]++;
                end
                if (rsp_valid[r] && rsp_ready[r]) begin
                    if (got_cnt[r] < DEPTH) begin
                        got_rsp[r][got_cnt[r]] = rsp[r];
                    end
                    got_cnt[r]++;
                end
                if (got_cnt[r] < exp_cnt[r]) begin
                    done = 1'b0;
                end
            end
            cycles++;
            if (!done && cycles >= WAIT_LIMIT) begin
                abort_run("timeout: row responses did not all arrive");
                return;
            end
        end
        @(negedge clk);
        req_valid = '0;
        for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
            check_value(got_cnt[r] == exp_cnt[r], $sformatf("row %0d gave %0d responses, expected %0d",
                r, got_cnt[r], exp_cnt[r]));
            for (int i = 0; i < exp_cnt[r] && i < got_cnt[r]; i++) begin
                check_value(got_rsp[r][i].data == exp_weight[r][i]
                    && got_rsp[r][i].last == exp_req[r][i].last,
                    $sformatf("row %0d item %0d got %h last %b, expected %h last %b", r, i,
                    got_rsp[r][i].data, got_rsp[r][i].last, exp_weight[r][i], exp_req[r][i].last));
            end
            exp_cnt[r] = 0;
        end
        check_value(mem_reads - reads_before == exp_reads, $sformatf(
            "%0d memory reads, expected %0d", mem_reads - reads_before, exp_reads));
    endtask

    // ==============================
    // Case reader
    // ==============================
    initial begin : main
        int         fd;
        int         n;
        int         mode_v;
        int         row_v;
        int         addr_v;
        int         last_v;
        int         weight_v;
        int         reads_v;
        int         errors_before;
        string      line;
        string      name;
        logic [7:0] kind;

        void'($urandom(32'h75d6dbc9));
        rst_n        = 1'b0;
        cfg_valid    = 1'b0;
        cfg_cache_en = 1'b0;
        req_valid    = '0;
        req          = '0;
        for (int r = 0; r < wcache_pkg::NUM_ROWS; r++) begin
            exp_cnt[r] = 0;
            got_cnt[r] = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_value(cfg_ready && req_ready == '0 && rsp_valid == '0 && !mem_req_valid,
            "outputs not idle after reset");

        fd = $fopen("verification/weight_cache_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open verification/weight_cache_cases.txt");
        end else begin
            while (!aborted && !$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (n <= 0 || line.len() < 2 || line.getc(0) == "#") begin
                    continue;    // Blank or comment line
                end
                kind = line.getc(0);
                n    = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %d",
                    mode_v, row_v, addr_v, last_v, weight_v, reads_v);
                if (n != 6 || row_v < 0 || row_v >= wcache_pkg::NUM_ROWS) begin
                    abort_run($sformatf("case line not understood: %s", line));
                    continue;
                end
                errors_before = errors;
                name          = "";
                case (kind)
                    "C": begin
                        name = (mode_v[0]) ? "configure cached" : "configure bypass";
                        drive_config(mode_v[0]);
                    end
                    "I": begin
                        name = "return to idle";
                        return_to_idle();
                    end
                    "R": begin
                        name = $sformatf("row %0d read %h", row_v, addr_v);
                        queue_request(row_v, addr_v, last_v, weight_v);
                        if (!aborted) begin
                            run_batch(reads_v);
                        end
                    end
                    "P": queue_request(row_v, addr_v, last_v, weight_v);
                    "G": begin
                        name = "all rows batch";
                        run_batch(reads_v);
                    end
                    default: abort_run($sformatf("unknown case kind in line: %s", line));
                endcase
                if (name.len() != 0) begin
                    cases_run++;
                    if (errors == errors_before) begin
                        $display("case %0d %s ok", cases_run, name);
                    end else begin
                        $display("case %0d %s: %0d error(s)", cases_run, name,
                            errors - errors_before);
                    end
                end
            end
            $fclose(fd);
        end

        $display("cases run: %0d, checks: %0d, errors: %0d", cases_run, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
